// File: src/exec_pkg.sv
`default_nettype none

package exec_pkg;

  localparam int data_w     = 32;
  localparam int reg_n      = 16;
  localparam int reg_aw     = 4;
  localparam int shamt_w    = 5;
  localparam int flag_w     = 4;
  localparam int alu_func_w = 9;

  // flag positions in the nzcv vector.
  localparam int flag_n = 3;
  localparam int flag_z = 2;
  localparam int flag_c = 1;
  localparam int flag_v = 0;

  // alu function word: swap, invert b, carry-in select, carry-out select, output select.
  localparam int fn_swap   = 8;
  localparam int fn_inv    = 7;
  localparam int fn_cin_hi = 6;
  localparam int fn_cin_lo = 5;
  localparam int fn_cout   = 4;
  localparam int fn_out_hi = 3;
  localparam int fn_out_lo = 0;

  localparam logic cout_adder = 1'b0;
  localparam logic cout_shift = 1'b1;

  // first sixteen follow the arm data-processing encoding.
  typedef enum logic [4:0] {
    op_and  = 5'd0,
    op_eor  = 5'd1,
    op_sub  = 5'd2,
    op_rsb  = 5'd3,
    op_add  = 5'd4,
    op_adc  = 5'd5,
    op_sbc  = 5'd6,
    op_rsc  = 5'd7,
    op_tst  = 5'd8,
    op_teq  = 5'd9,
    op_cmp  = 5'd10,
    op_cmn  = 5'd11,
    op_orr  = 5'd12,
    op_mov  = 5'd13,
    op_bic  = 5'd14,
    op_mvn  = 5'd15,
    op_uxtb = 5'd16,
    op_uxth = 5'd17,
    op_sxtb = 5'd18,
    op_sxth = 5'd19
  } alu_op_e;

  typedef enum logic [1:0] {
    sh_lsl = 2'd0,
    sh_lsr = 2'd1,
    sh_asr = 2'd2,
    sh_ror = 2'd3
  } shift_e;

  typedef enum logic [3:0] {
    cond_eq = 4'h0,
    cond_ne = 4'h1,
    cond_cs = 4'h2,
    cond_cc = 4'h3,
    cond_mi = 4'h4,
    cond_pl = 4'h5,
    cond_vs = 4'h6,
    cond_vc = 4'h7,
    cond_hi = 4'h8,
    cond_ls = 4'h9,
    cond_ge = 4'ha,
    cond_lt = 4'hb,
    cond_gt = 4'hc,
    cond_le = 4'hd,
    cond_al = 4'he
  } cond_e;

  typedef enum logic [1:0] {
    cin_zero  = 2'd0,
    cin_one   = 2'd1,
    cin_carry = 2'd2  // status c.
  } cin_sel_e;

  typedef enum logic [3:0] {
    out_b      = 4'd0,
    out_add    = 4'd1,
    out_zext16 = 4'd2,
    out_zext8  = 4'd3,
    out_sext16 = 4'd4,
    out_sext8  = 4'd5,
    out_xor    = 4'd6,
    out_or     = 4'd7,
    out_and    = 4'd8
  } out_sel_e;

endpackage

`default_nettype wire

// File: src/barrel_shift.sv
`default_nettype none

module barrel_shift (
  input  logic [exec_pkg::data_w-1:0]  i_data,
  input  exec_pkg::shift_e             i_shift_type,
  input  logic [exec_pkg::shamt_w-1:0] i_shift_amt,
  input  logic                         i_carry_in,
  output logic [exec_pkg::data_w-1:0]  o_data,
  output logic                         o_carry
);

  logic [exec_pkg::shamt_w-1:0] last_out;  // index of the last bit shifted out on right shifts.

  assign last_out = i_shift_amt - 1'b1;

  always_comb begin
    o_data  = i_data;
    o_carry = i_carry_in;  // zero amount keeps c.
    if (i_shift_amt != '0) begin
      case (i_shift_type)
        exec_pkg::sh_lsl: begin
          o_data  = i_data << i_shift_amt;
          o_carry = i_data[exec_pkg::data_w - i_shift_amt];
        end
        exec_pkg::sh_lsr: begin
          o_data  = i_data >> i_shift_amt;
          o_carry = i_data[last_out];
        end
        exec_pkg::sh_asr: begin
          o_data  = $signed(i_data) >>> i_shift_amt;
          o_carry = i_data[last_out];
        end
        exec_pkg::sh_ror: begin
          // bit 31 of the rotated word is the carry.
          o_data  = (i_data >> i_shift_amt) |
                    (i_data << (exec_pkg::data_w - i_shift_amt));
          o_carry = i_data[last_out];
        end
        default: begin
          o_data  = i_data;
          o_carry = i_carry_in;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/alu.sv
`default_nettype none

module alu (
  input  logic [exec_pkg::data_w-1:0]     i_a_in,
  input  logic [exec_pkg::data_w-1:0]     i_b_in,
  input  logic                            i_barrel_shift_carry,
  input  logic                            i_status_bits_carry,
  input  logic [exec_pkg::alu_func_w-1:0] i_function,
  output logic [exec_pkg::data_w-1:0]     o_out,
  output logic [exec_pkg::flag_w-1:0]     o_flags
);

  localparam int msb = exec_pkg::data_w - 1;

  logic               swap_sel;
  logic               not_sel;
  exec_pkg::cin_sel_e cin_sel;
  logic               cout_sel;
  exec_pkg::out_sel_e out_sel;
  logic [msb:0]       a;
  logic [msb:0]       b;
  logic [msb:0]       b_not;
  logic               carry_in;
  logic [msb+1:0]     fadder_out;
  logic               carry_out;
  logic               overflow_out;

  assign swap_sel = i_function[exec_pkg::fn_swap];
  assign not_sel  = i_function[exec_pkg::fn_inv];
  assign cin_sel  = exec_pkg::cin_sel_e'(i_function[exec_pkg::fn_cin_hi:exec_pkg::fn_cin_lo]);
  assign cout_sel = i_function[exec_pkg::fn_cout];
  assign out_sel  = exec_pkg::out_sel_e'(i_function[exec_pkg::fn_out_hi:exec_pkg::fn_out_lo]);

  assign a     = swap_sel ? i_b_in : i_a_in;
  assign b     = swap_sel ? i_a_in : i_b_in;
  assign b_not = not_sel ? ~b : b;

  always_comb begin
    case (cin_sel)
      exec_pkg::cin_zero: carry_in = 1'b0;
      exec_pkg::cin_one:  carry_in = 1'b1;
      default:            carry_in = i_status_bits_carry;
    endcase
  end

  assign fadder_out = {1'b0, a} + {1'b0, b_not} + {{exec_pkg::data_w{1'b0}}, carry_in};

  assign carry_out = (cout_sel == exec_pkg::cout_adder) ? fadder_out[msb+1]
                                                        : i_barrel_shift_carry;

  // signed overflow, add path only.
  assign overflow_out = (out_sel == exec_pkg::out_add) &&
                        ((!a[msb] && !b_not[msb] &&  fadder_out[msb]) ||
                         ( a[msb] &&  b_not[msb] && !fadder_out[msb]));

  always_comb begin
    case (out_sel)
      exec_pkg::out_b:      o_out = b_not;
      exec_pkg::out_add:    o_out = fadder_out[msb:0];
      exec_pkg::out_zext16: o_out = {16'd0, b_not[15:0]};
      exec_pkg::out_zext8:  o_out = {24'd0, b_not[7:0]};
      exec_pkg::out_sext16: o_out = {{16{b_not[15]}}, b_not[15:0]};
      exec_pkg::out_sext8:  o_out = {{24{b_not[7]}}, b_not[7:0]};
      exec_pkg::out_xor:    o_out = a ^ b_not;
      exec_pkg::out_or:     o_out = a | b_not;
      default:              o_out = a & b_not;
    endcase
  end

  always_comb begin
    o_flags                   = '0;
    o_flags[exec_pkg::flag_n] = o_out[msb];
    o_flags[exec_pkg::flag_z] = ~|o_out;
    o_flags[exec_pkg::flag_c] = carry_out;
    o_flags[exec_pkg::flag_v] = overflow_out;
  end

  // the control decoder only emits codes up to the and select.
  always_comb begin
    a_out_sel_range: assert ($isunknown(out_sel) || out_sel <= exec_pkg::out_and)
      else $error("alu output select out of range");
  end

endmodule

`default_nettype wire

// File: src/reg_bank.sv
`default_nettype none

module reg_bank (
  input  logic                        i_clk,
  input  logic                        i_arst_n,
  input  logic [exec_pkg::reg_aw-1:0] i_raddr_a,
  input  logic [exec_pkg::reg_aw-1:0] i_raddr_b,
  input  logic                        i_we,
  input  logic [exec_pkg::reg_aw-1:0] i_waddr,
  input  logic [exec_pkg::data_w-1:0] i_wdata,
  output logic [exec_pkg::data_w-1:0] o_rdata_a,
  output logic [exec_pkg::data_w-1:0] o_rdata_b
);

  logic [exec_pkg::data_w-1:0] regs [exec_pkg::reg_n];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < exec_pkg::reg_n; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // read in the write cycle sees the old value.
  assign o_rdata_a = regs[i_raddr_a];
  assign o_rdata_b = regs[i_raddr_b];

  a_waddr_known: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_we |-> !$isunknown(i_waddr))
    else $error("register write with unknown address");

endmodule

`default_nettype wire

// File: src/exec_ctrl.sv
`default_nettype none

module exec_ctrl (
  input  logic                            i_clk,
  input  logic                            i_arst_n,
  input  logic                            i_valid,
  input  exec_pkg::alu_op_e               i_opcode,
  input  exec_pkg::cond_e                 i_cond,
  input  logic                            i_set_flags,
  input  logic [exec_pkg::reg_aw-1:0]     i_rd,
  input  logic [exec_pkg::data_w-1:0]     i_alu_out,
  input  logic [exec_pkg::flag_w-1:0]     i_alu_flags,
  output logic [exec_pkg::alu_func_w-1:0] o_alu_function,
  output logic [exec_pkg::flag_w-1:0]     o_flags,
  output logic                            o_reg_we,
  output logic [exec_pkg::reg_aw-1:0]     o_reg_waddr,
  output logic                            o_res_valid,
  output logic                            o_res_written,
  output logic [exec_pkg::reg_aw-1:0]     o_res_rd,
  output logic [exec_pkg::data_w-1:0]     o_res_data
);

  logic [exec_pkg::flag_w-1:0] flags_q;
  logic                        n_flag;
  logic                        z_flag;
  logic                        c_flag;
  logic                        v_flag;
  logic                        cond_pass;
  logic                        is_cmp;
  logic                        exec_en;
  logic                        flag_we;
  logic                        swap_sel;
  logic                        inv_sel;
  exec_pkg::cin_sel_e          cin_sel;
  logic                        cout_sel;
  exec_pkg::out_sel_e          out_sel;

  assign n_flag = flags_q[exec_pkg::flag_n];
  assign z_flag = flags_q[exec_pkg::flag_z];
  assign c_flag = flags_q[exec_pkg::flag_c];
  assign v_flag = flags_q[exec_pkg::flag_v];

  always_comb begin
    case (i_cond)
      exec_pkg::cond_eq: cond_pass = z_flag;
      exec_pkg::cond_ne: cond_pass = !z_flag;
      exec_pkg::cond_cs: cond_pass = c_flag;
      exec_pkg::cond_cc: cond_pass = !c_flag;
      exec_pkg::cond_mi: cond_pass = n_flag;
      exec_pkg::cond_pl: cond_pass = !n_flag;
      exec_pkg::cond_vs: cond_pass = v_flag;
      exec_pkg::cond_vc: cond_pass = !v_flag;
      exec_pkg::cond_hi: cond_pass = c_flag && !z_flag;
      exec_pkg::cond_ls: cond_pass = !c_flag || z_flag;
      exec_pkg::cond_ge: cond_pass = (n_flag == v_flag);
      exec_pkg::cond_lt: cond_pass = (n_flag != v_flag);
      exec_pkg::cond_gt: cond_pass = !z_flag && (n_flag == v_flag);
      exec_pkg::cond_le: cond_pass = z_flag || (n_flag != v_flag);
      exec_pkg::cond_al: cond_pass = 1'b1;
      default:           cond_pass = 1'b0;  // nv encoding never runs.
    endcase
  end

  assign is_cmp = i_opcode inside {exec_pkg::op_tst, exec_pkg::op_teq,
                                   exec_pkg::op_cmp, exec_pkg::op_cmn};

  assign exec_en     = i_valid & cond_pass;
  assign flag_we     = exec_en & (i_set_flags | is_cmp);  // compares always set flags.
  assign o_reg_we    = exec_en & ~is_cmp;
  assign o_reg_waddr = i_rd;

  // opcode to alu function word.
  always_comb begin
    swap_sel = 1'b0;
    inv_sel  = 1'b0;
    cin_sel  = exec_pkg::cin_zero;
    cout_sel = exec_pkg::cout_shift;
    out_sel  = exec_pkg::out_b;
    case (i_opcode)
      exec_pkg::op_and,
      exec_pkg::op_tst:  out_sel = exec_pkg::out_and;
      exec_pkg::op_eor,
      exec_pkg::op_teq:  out_sel = exec_pkg::out_xor;
      exec_pkg::op_orr:  out_sel = exec_pkg::out_or;
      exec_pkg::op_bic: begin
        inv_sel = 1'b1;
        out_sel = exec_pkg::out_and;
      end
      exec_pkg::op_mvn:  inv_sel = 1'b1;
      exec_pkg::op_sub,
      exec_pkg::op_cmp: begin  // a + ~b + 1.
        inv_sel  = 1'b1;
        cin_sel  = exec_pkg::cin_one;
        cout_sel = exec_pkg::cout_adder;
        out_sel  = exec_pkg::out_add;
      end
      exec_pkg::op_rsb: begin
        swap_sel = 1'b1;
        inv_sel  = 1'b1;
        cin_sel  = exec_pkg::cin_one;
        cout_sel = exec_pkg::cout_adder;
        out_sel  = exec_pkg::out_add;
      end
      exec_pkg::op_add,
      exec_pkg::op_cmn: begin
        cout_sel = exec_pkg::cout_adder;
        out_sel  = exec_pkg::out_add;
      end
      exec_pkg::op_adc: begin
        cin_sel  = exec_pkg::cin_carry;
        cout_sel = exec_pkg::cout_adder;
        out_sel  = exec_pkg::out_add;
      end
      exec_pkg::op_sbc: begin
        inv_sel  = 1'b1;
        cin_sel  = exec_pkg::cin_carry;
        cout_sel = exec_pkg::cout_adder;
        out_sel  = exec_pkg::out_add;
      end
      exec_pkg::op_rsc: begin
        swap_sel = 1'b1;
        inv_sel  = 1'b1;
        cin_sel  = exec_pkg::cin_carry;
        cout_sel = exec_pkg::cout_adder;
        out_sel  = exec_pkg::out_add;
      end
      exec_pkg::op_uxtb: out_sel = exec_pkg::out_zext8;
      exec_pkg::op_uxth: out_sel = exec_pkg::out_zext16;
      exec_pkg::op_sxtb: out_sel = exec_pkg::out_sext8;
      exec_pkg::op_sxth: out_sel = exec_pkg::out_sext16;
      default:           out_sel = exec_pkg::out_b;  // mov.
    endcase
  end

  assign o_alu_function = {swap_sel, inv_sel, cin_sel, cout_sel, out_sel};

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      flags_q       <= '0;
      o_res_valid   <= 1'b0;
      o_res_written <= 1'b0;
    end else begin
      if (flag_we) begin
        flags_q <= i_alu_flags;
      end
      o_res_valid   <= i_valid;
      o_res_written <= o_reg_we;
    end
  end

  // result payload, kept even for skipped ops and compares.
  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_res_rd   <= i_rd;
      o_res_data <= i_alu_out;
    end
  end

  assign o_flags = flags_q;

  a_flags_need_valid: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !i_valid |=> $stable(flags_q))
    else $error("flags changed without an instruction");

  a_written_in_valid: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_res_written |-> o_res_valid)
    else $error("register write reported outside a result cycle");

endmodule

`default_nettype wire

// File: src/exec_top.sv
`default_nettype none

module exec_top (
  input  logic                         i_clk,
  input  logic                         i_arst_n,
  input  logic                         i_valid,
  input  exec_pkg::alu_op_e            i_opcode,
  input  exec_pkg::cond_e              i_cond,
  input  logic                         i_set_flags,
  input  logic [exec_pkg::reg_aw-1:0]  i_rd,
  input  logic [exec_pkg::reg_aw-1:0]  i_rn,
  input  logic [exec_pkg::reg_aw-1:0]  i_rm,
  input  logic                         i_use_imm,
  input  logic [exec_pkg::data_w-1:0]  i_imm,
  input  exec_pkg::shift_e             i_shift_type,
  input  logic [exec_pkg::shamt_w-1:0] i_shift_amt,
  output logic                         o_res_valid,
  output logic                         o_res_written,
  output logic [exec_pkg::reg_aw-1:0]  o_res_rd,
  output logic [exec_pkg::data_w-1:0]  o_res_data,
  output logic [exec_pkg::flag_w-1:0]  o_flags
);

  logic [exec_pkg::data_w-1:0]     rn_data;
  logic [exec_pkg::data_w-1:0]     rm_data;
  logic [exec_pkg::data_w-1:0]     op2_raw;
  logic [exec_pkg::data_w-1:0]     op2_shifted;
  logic                            shift_carry;
  logic [exec_pkg::alu_func_w-1:0] alu_function;
  logic [exec_pkg::data_w-1:0]     alu_out;
  logic [exec_pkg::flag_w-1:0]     alu_flags;
  logic                            reg_we;
  logic [exec_pkg::reg_aw-1:0]     reg_waddr;

  reg_bank bank_i (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_raddr_a (i_rn),
    .i_raddr_b (i_rm),
    .i_we      (reg_we),
    .i_waddr   (reg_waddr),
    .i_wdata   (alu_out),
    .o_rdata_a (rn_data),
    .o_rdata_b (rm_data)
  );

  assign op2_raw = i_use_imm ? i_imm : rm_data;  // immediate goes through the shifter too.

  barrel_shift shift_i (
    .i_data       (op2_raw),
    .i_shift_type (i_shift_type),
    .i_shift_amt  (i_shift_amt),
    .i_carry_in   (o_flags[exec_pkg::flag_c]),
    .o_data       (op2_shifted),
    .o_carry      (shift_carry)
  );

  alu alu_i (
    .i_a_in               (rn_data),
    .i_b_in               (op2_shifted),
    .i_barrel_shift_carry (shift_carry),
    .i_status_bits_carry  (o_flags[exec_pkg::flag_c]),
    .i_function           (alu_function),
    .o_out                (alu_out),
    .o_flags              (alu_flags)
  );

  exec_ctrl ctrl_i (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_valid        (i_valid),
    .i_opcode       (i_opcode),
    .i_cond         (i_cond),
    .i_set_flags    (i_set_flags),
    .i_rd           (i_rd),
    .i_alu_out      (alu_out),
    .i_alu_flags    (alu_flags),
    .o_alu_function (alu_function),
    .o_flags        (o_flags),
    .o_reg_we       (reg_we),
    .o_reg_waddr    (reg_waddr),
    .o_res_valid    (o_res_valid),
    .o_res_written  (o_res_written),
    .o_res_rd       (o_res_rd),
    .o_res_data     (o_res_data)
  );

endmodule

`default_nettype wire

// File: dv/exec_tb.sv
`default_nettype none

module exec_tb;

  localparam int dw = exec_pkg::data_w;
  localparam int aw = exec_pkg::reg_aw;
  localparam int timeout_cycles = 50;

  logic                         i_clk;
  logic                         i_arst_n;
  logic                         i_valid;
  exec_pkg::alu_op_e            i_opcode;
  exec_pkg::cond_e              i_cond;
  logic                         i_set_flags;
  logic [aw-1:0]                i_rd;
  logic [aw-1:0]                i_rn;
  logic [aw-1:0]                i_rm;
  logic                         i_use_imm;
  logic [dw-1:0]                i_imm;
  exec_pkg::shift_e             i_shift_type;
  logic [exec_pkg::shamt_w-1:0] i_shift_amt;
  logic                         o_res_valid;
  logic                         o_res_written;
  logic [aw-1:0]                o_res_rd;
  logic [dw-1:0]                o_res_data;
  logic [exec_pkg::flag_w-1:0]  o_flags;

  // reference model state and the expected result bundle.
  logic [dw-1:0]               model_regs [exec_pkg::reg_n];
  logic [exec_pkg::flag_w-1:0] model_flags;
  logic                        exp_valid;
  logic                        exp_written;
  logic [aw-1:0]               exp_rd;
  logic [dw-1:0]               exp_data;
  logic [exec_pkg::flag_w-1:0] exp_flags;

  exec_top dut_i (.*);

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped on first failure");
  endtask

  task automatic report_mismatch(input string sig, input logic [dw-1:0] got,
                                 input logic [dw-1:0] exp);
    $display("Error: time %0t, signal %s, got %h, expected %h", $time, sig, got, exp);
    abort_run();
  endtask

  // odd codes invert the even ones.
  function automatic logic cond_holds(exec_pkg::cond_e c, logic [3:0] f);
    logic n;
    logic z;
    logic cf;
    logic v;
    logic t;
    n  = f[exec_pkg::flag_n];
    z  = f[exec_pkg::flag_z];
    cf = f[exec_pkg::flag_c];
    v  = f[exec_pkg::flag_v];
    case (c[3:1])
      3'd0:    t = z;
      3'd1:    t = cf;
      3'd2:    t = n;
      3'd3:    t = v;
      3'd4:    t = cf & ~z;
      3'd5:    t = (n == v);
      3'd6:    t = ~z & (n == v);
      default: t = 1'b1;
    endcase
    return c[0] ? ~t : t;
  endfunction

  // returns {carry, data}.
  function automatic logic [dw:0] shift_model(logic [dw-1:0] d, exec_pkg::shift_e st,
                                               logic [4:0] amt, logic c_old);
    logic [2*dw-1:0] wide;
    logic [dw:0]     res;
    res = {c_old, d};
    if (amt != 0) begin
      case (st)
        exec_pkg::sh_lsl: begin
          wide = {32'd0, d} << amt;
          res  = {wide[32], wide[31:0]};
        end
        exec_pkg::sh_lsr: begin
          wide = {d, 32'd0} >> amt;
          res  = {wide[31], wide[63:32]};
        end
        exec_pkg::sh_asr: begin
          wide = $signed({d, 32'd0}) >>> amt;
          res  = {wide[31], wide[63:32]};
        end
        default: begin
          wide = {d, d} >> amt;
          res  = {wide[31], wide[31:0]};
        end
      endcase
    end
    return res;
  endfunction

  // returns {nzcv, result}.
  function automatic logic [dw+3:0] alu_model(exec_pkg::alu_op_e op, logic [dw-1:0] a,
                                              logic [dw-1:0] b, logic sh_c, logic c_old);
    logic [dw:0]   sum;
    logic [dw-1:0] r;
    logic [dw-1:0] x;
    logic [dw-1:0] y;
    logic          c;
    logic          v;
    logic          bit_in;
    c = sh_c;
    v = 1'b0;
    case (op)
      exec_pkg::op_and, exec_pkg::op_tst: r = a & b;
      exec_pkg::op_eor, exec_pkg::op_teq: r = a ^ b;
      exec_pkg::op_orr:  r = a | b;
      exec_pkg::op_bic:  r = a & ~b;
      exec_pkg::op_mvn:  r = ~b;
      exec_pkg::op_uxtb: r = b & 32'h0000_00ff;
      exec_pkg::op_uxth: r = b & 32'h0000_ffff;
      exec_pkg::op_sxtb: r = 32'($signed(b[7:0]));
      exec_pkg::op_sxth: r = 32'($signed(b[15:0]));
      exec_pkg::op_add, exec_pkg::op_cmn, exec_pkg::op_adc: begin
        bit_in = (op == exec_pkg::op_adc) ? c_old : 1'b0;
        sum    = {1'b0, a} + {1'b0, b} + 33'(bit_in);
        r      = sum[dw-1:0];
        c      = sum[dw];
        v      = (a[31] == b[31]) && (r[31] != a[31]);
      end
      exec_pkg::op_sub, exec_pkg::op_cmp, exec_pkg::op_sbc,
      exec_pkg::op_rsb, exec_pkg::op_rsc: begin
        x      = (op inside {exec_pkg::op_rsb, exec_pkg::op_rsc}) ? b : a;
        y      = (op inside {exec_pkg::op_rsb, exec_pkg::op_rsc}) ? a : b;
        bit_in = (op inside {exec_pkg::op_sbc, exec_pkg::op_rsc}) ? ~c_old : 1'b0;  // borrow.
        sum    = {1'b0, x} - {1'b0, y} - 33'(bit_in);
        r      = sum[dw-1:0];
        c      = ~sum[dw];  // no borrow.
        v      = (x[31] != y[31]) && (r[31] != x[31]);
      end
      default: r = b;
    endcase
    return {r[31], (r == 0), c, v, r};
  endfunction

  always @(posedge i_clk or negedge i_arst_n) begin : model_step
    logic [dw:0]   shifted;
    logic [dw+3:0] outcome;
    logic          run;
    logic          is_cmp;
    if (!i_arst_n) begin
      for (int i = 0; i < exec_pkg::reg_n; i++) begin
        model_regs[i] = '0;
      end
      model_flags = '0;
      exp_valid   <= 1'b0;
      exp_written <= 1'b0;
      exp_rd      <= '0;
      exp_data    <= '0;
      exp_flags   <= '0;
    end else begin
      exp_valid   <= i_valid;
      exp_written <= 1'b0;
      if (i_valid) begin
        shifted = shift_model(i_use_imm ? i_imm : model_regs[i_rm], i_shift_type,
                              i_shift_amt, model_flags[exec_pkg::flag_c]);
        outcome = alu_model(i_opcode, model_regs[i_rn], shifted[dw-1:0], shifted[dw],
                            model_flags[exec_pkg::flag_c]);
        run     = cond_holds(i_cond, model_flags);
        is_cmp  = i_opcode inside {exec_pkg::op_tst, exec_pkg::op_teq,
                                   exec_pkg::op_cmp, exec_pkg::op_cmn};
        if (run && !is_cmp) model_regs[i_rd] = outcome[dw-1:0];
        if (run && (i_set_flags || is_cmp)) model_flags = outcome[dw+3:dw];
        exp_written <= run && !is_cmp;
        exp_rd      <= i_rd;
        exp_data    <= outcome[dw-1:0];
      end
      exp_flags <= model_flags;  // flags after the update.
    end
  end

  a_res_valid: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_res_valid == exp_valid)
    else report_mismatch("o_res_valid", 32'($sampled(o_res_valid)), 32'($sampled(exp_valid)));

  a_res_written: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_res_written == exp_written)
    else report_mismatch("o_res_written", 32'($sampled(o_res_written)),
                         32'($sampled(exp_written)));

  a_res_rd: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    exp_valid |-> o_res_rd == exp_rd)
    else report_mismatch("o_res_rd", 32'($sampled(o_res_rd)), 32'($sampled(exp_rd)));

  a_res_data: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    exp_valid |-> o_res_data == exp_data)
    else report_mismatch("o_res_data", $sampled(o_res_data), $sampled(exp_data));

  a_flags: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_flags == exp_flags)
    else report_mismatch("o_flags", 32'($sampled(o_flags)), 32'($sampled(exp_flags)));

  task automatic issue(
    input exec_pkg::alu_op_e op,
    input exec_pkg::cond_e   cond,
    input logic              sf,
    input logic [aw-1:0]     rd,
    input logic [aw-1:0]     rn,
    input logic [aw-1:0]     rm,
    input logic              use_imm,
    input logic [dw-1:0]     imm,
    input exec_pkg::shift_e  st,
    input logic [4:0]        amt
  );
    @(posedge i_clk);
    i_valid      <= 1'b1;
    i_opcode     <= op;
    i_cond       <= cond;
    i_set_flags  <= sf;
    i_rd         <= rd;
    i_rn         <= rn;
    i_rm         <= rm;
    i_use_imm    <= use_imm;
    i_imm        <= imm;
    i_shift_type <= st;
    i_shift_amt  <= amt;
  endtask

  task automatic load_imm(input logic [aw-1:0] rd, input logic [dw-1:0] value);
    issue(exec_pkg::op_mov, exec_pkg::cond_al, 1'b0, rd, '0, '0, 1'b1, value,
          exec_pkg::sh_lsl, 5'd0);
  endtask

  task automatic go_idle();
    @(posedge i_clk);
    i_valid <= 1'b0;
  endtask

  // waits until no result is pending.
  task automatic wait_quiet(input string what);
    int cycles;
    cycles = 0;
    while ((exp_valid !== 1'b0 || o_res_valid !== 1'b0) && cycles < timeout_cycles) begin
      @(posedge i_clk);
      cycles++;
    end
    if (exp_valid !== 1'b0 || o_res_valid !== 1'b0) begin
      $display("Timeout: results still pending while %s", what);
      abort_run();
    end
  endtask

  function automatic logic [dw-1:0] pick_value();
    case ($urandom % 6)
      0:       return 32'h0000_0000;
      1:       return 32'h7fff_ffff;
      2:       return 32'h8000_0000;
      3:       return 32'hffff_ffff;
      default: return $urandom;
    endcase
  endfunction

  initial begin : stimulus
    exec_pkg::alu_op_e arith_ops [8];
    exec_pkg::alu_op_e logic_ops [6];
    exec_pkg::alu_op_e ext_ops [4];
    logic [dw-1:0]     ext_vals [4];
    void'($urandom(8));
    arith_ops = '{exec_pkg::op_add, exec_pkg::op_adc, exec_pkg::op_sub, exec_pkg::op_sbc,
                  exec_pkg::op_rsb, exec_pkg::op_rsc, exec_pkg::op_cmp, exec_pkg::op_cmn};
    logic_ops = '{exec_pkg::op_and, exec_pkg::op_eor, exec_pkg::op_orr,
                  exec_pkg::op_bic, exec_pkg::op_tst, exec_pkg::op_teq};
    ext_ops   = '{exec_pkg::op_uxtb, exec_pkg::op_uxth, exec_pkg::op_sxtb, exec_pkg::op_sxth};
    ext_vals  = '{32'h0000_0080, 32'h0000_8000, 32'hffff_7f7f, 32'h1234_8f80};
    i_arst_n     = 1'b0;
    i_valid      = 1'b0;
    i_opcode     = exec_pkg::op_mov;
    i_cond       = exec_pkg::cond_al;
    i_set_flags  = 1'b0;
    i_rd         = '0;
    i_rn         = '0;
    i_rm         = '0;
    i_use_imm    = 1'b0;
    i_imm        = '0;
    i_shift_type = exec_pkg::sh_lsl;
    i_shift_amt  = '0;
    repeat (2) @(posedge i_clk);
    i_arst_n <= 1'b1;
    wait_quiet("settling after reset");

    // register path, reset zeros and back-to-back reads.
    load_imm(4'd1, 32'h1234_5678);
    issue(exec_pkg::op_mvn, exec_pkg::cond_al, 1'b1, 4'd2, 4'd0, 4'd0, 1'b1, '0,
          exec_pkg::sh_lsl, 5'd0);
    issue(exec_pkg::op_add, exec_pkg::cond_al, 1'b1, 4'd3, 4'd1, 4'd2, 1'b0, '0,
          exec_pkg::sh_lsl, 5'd0);
    issue(exec_pkg::op_add, exec_pkg::cond_al, 1'b0, 4'd4, 4'd5, 4'd6, 1'b0, '0,
          exec_pkg::sh_lsl, 5'd0);
    issue(exec_pkg::op_add, exec_pkg::cond_al, 1'b0, 4'd5, 4'd3, 4'd3, 1'b0, '0,
          exec_pkg::sh_lsl, 5'd0);

    for (int i = 0; i < 48; i++) begin
      load_imm(4'd1, pick_value());
      load_imm(4'd2, pick_value());
      issue(arith_ops[i % 8], exec_pkg::cond_al, 1'($urandom), 4'd6, 4'd1, 4'd2, 1'b0, '0,
            exec_pkg::sh_lsl, 5'd0);
      issue(logic_ops[i % 6], exec_pkg::cond_al, 1'($urandom), 4'd7, 4'd1, 4'd2, 1'b0, '0,
            exec_pkg::shift_e'(i % 4), (i % 5 == 0) ? 5'd0 : 5'($urandom));
    end

    foreach (ext_ops[i]) begin
      foreach (ext_vals[j]) begin
        issue(ext_ops[i], exec_pkg::cond_al, 1'b1, 4'd8, 4'd0, 4'd0, 1'b1, ext_vals[j],
              exec_pkg::sh_lsl, 5'd0);
      end
    end

    // every condition after a compare of equal values, then of random ones.
    for (int j = 0; j < 3; j++) begin
      for (int c = 0; c < 15; c++) begin
        load_imm(4'd1, (j == 0) ? 32'h5 : pick_value());
        load_imm(4'd2, (j == 0) ? 32'h5 : pick_value());
        issue(exec_pkg::op_cmp, exec_pkg::cond_al, 1'b0, 4'd0, 4'd1, 4'd2, 1'b0, '0,
              exec_pkg::sh_lsl, 5'd0);
        issue(exec_pkg::op_add, exec_pkg::cond_e'(c), 1'b1, 4'd9, 4'd1, 4'd2, 1'b0, '0,
              exec_pkg::sh_lsl, 5'd0);
        issue(exec_pkg::op_mov, exec_pkg::cond_al, 1'b0, 4'd10, 4'd0, 4'd9, 1'b0, '0,
              exec_pkg::sh_lsl, 5'd0);  // reads r9 back.
      end
    end

    for (int i = 0; i < 200; i++) begin
      issue(exec_pkg::alu_op_e'($urandom % 20), exec_pkg::cond_e'($urandom % 15),
            1'($urandom), 4'($urandom), 4'($urandom), 4'($urandom), 1'($urandom),
            pick_value(), exec_pkg::shift_e'($urandom % 4), 5'($urandom));
    end

    go_idle();
    wait_quiet("draining results");
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
src/exec_pkg.sv
src/barrel_shift.sv
src/alu.sv
src/reg_bank.sv
src/exec_ctrl.sv
src/exec_top.sv
dv/exec_tb.sv
